//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --assert -j 0
TOP       = tb_service_driver
FILELIST  = files.f
LOG       = sim.log
PASS_MSG  = ALL CHECKS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- descriptor_builder.sv
// Command lookup, registered command byte, descriptor and word count
`include "service_defs.svh"

module descriptor_builder (
   input  logic                   CLK,
   input  logic                   RESETN,
   input  logic                   start,
   input  service_pkg::svc_cmd_t  start_cmd,
   output service_pkg::svc_cmd_t  serv_cmdbyte_req,
   output service_pkg::svc_desc_t serv_desc,
   output service_pkg::svc_count_t word_count
);

   // Lookup results for the accepted code
   service_pkg::svc_cmd_t   lut_cmd;
   service_pkg::svc_desc_t  lut_desc;
   service_pkg::svc_count_t lut_count;

   // ==============================
   // Command table
   // ==============================
   always_comb begin
      lut_cmd   = start_cmd;
      lut_desc  = '0;
      lut_count = '0;
      case (start_cmd)
         // No descriptor, no payload
         `CMD_SERIAL, `CMD_USERCODE, `CMD_SELFTEST: begin
         end
         `CMD_AES128: begin
            lut_desc.key     = {128'd0, `KEY_LOW128};
            lut_desc.iv      = `IV_PATTERN_A;
            lut_desc.mode    = `AES_MODE_DEC;
            lut_desc.nblocks = 16'd1;
            // Four words per block
            lut_count        = 6'd4;
         end
         `CMD_AES256: begin
            lut_desc.key     = `KEY_PATTERN;
            lut_desc.iv      = `IV_PATTERN_B;
            lut_desc.mode    = `AES_MODE_ENC;
            lut_desc.nblocks = 16'd2;
            lut_desc.length  = 32'd1;
            lut_count        = 6'd8;
         end
         `CMD_SHA256: begin
            lut_desc.length = 32'd33;
            lut_count       = 6'd2;
         end
         `CMD_HMAC: begin
            lut_desc.key    = `KEY_PATTERN;
            lut_desc.length = 32'd9;
            lut_count       = 6'd3;
         end
         `CMD_INST: begin
            lut_desc.nrbg_length = 8'd4;
            lut_desc.nrbg_handle = `NRBG_HANDLE;
            lut_count            = 6'd1;
         end
         // Generate sends all NRBG fields as zero
         `CMD_GEN: begin
            lut_count = 6'd1;
         end
         `CMD_RESEED: begin
            lut_desc.nrbg_length    = 8'd32;
            lut_desc.nrbg_handle    = `NRBG_HANDLE;
            lut_desc.nrbg_addlength = 8'd7;
            lut_count               = 6'd2;
         end
         `CMD_UNINST: begin
            lut_desc.nrbg_handle = `NRBG_HANDLE;
         end
         // Unknown codes fall back to serial number
         default: begin
            lut_cmd = `CMD_SERIAL;
         end
      endcase
   end

   // ==============================
   // Enable cycle registers
   // ==============================
   // Loaded on start, cleared one cycle later
   always_ff @(posedge CLK or negedge RESETN) begin
      if (!RESETN) begin
         serv_cmdbyte_req <= '0;
         serv_desc        <= '0;
         word_count       <= '0;
      end else if (start) begin
         serv_cmdbyte_req <= lut_cmd;
         serv_desc        <= lut_desc;
         word_count       <= lut_count;
      end else begin
         serv_cmdbyte_req <= '0;
         serv_desc        <= '0;
         word_count       <= '0;
      end
   end

endmodule

//--- files.f
+incdir+.
service_pkg.sv
descriptor_builder.sv
payload_streamer.sv
service_sequencer.sv
service_driver_top.sv
service_asserts.sv
tb_service_driver.sv

//--- payload_streamer.sv
// Payload word counter and valid/ready write stream
`include "service_defs.svh"

module payload_streamer (
   input  logic                    CLK,
   input  logic                    RESETN,
   input  logic                    load,
   input  service_pkg::svc_count_t word_count,
   input  logic                    serv_data_wrdy,
   output logic                    serv_data_wvalid,
   output service_pkg::svc_word_t  serv_data_w,
   output logic                    stream_done
);

   // Words still owed to the service
   service_pkg::svc_count_t remaining;
   // Word on offer
   service_pkg::svc_word_t  word;
   logic                    xfer;

   // ==============================
   // Handshake
   // ==============================
   // Offer while words remain and hold until taken
   assign serv_data_wvalid = (remaining != '0);
   assign serv_data_w      = word;
   assign xfer             = serv_data_wvalid && serv_data_wrdy;

   // Zero count ends in the enable cycle itself
   // otherwise ends on the last transfer
   assign stream_done = (load && (word_count == '0))
                     || (xfer && (remaining == service_pkg::svc_count_t'(1)));

   // ==============================
   // Remaining word counter
   // ==============================
   always_ff @(posedge CLK or negedge RESETN) begin
      if (!RESETN) begin
         remaining <= '0;
      end else if (load) begin
         remaining <= word_count;
      end else if (xfer) begin
         remaining <= remaining - service_pkg::svc_count_t'(1);
      end
   end

   // Word value restarts at the payload base on every load
   always_ff @(posedge CLK or negedge RESETN) begin
      if (!RESETN) begin
         word <= '0;
      end else if (load) begin
         word <= `PAYLOAD_START;
      end else if (xfer) begin
         word <= word + service_pkg::svc_word_t'(1);
      end
   end

endmodule

//--- service_asserts.sv
// Concurrent checks on enable pulse width, request accept and write handshake hold
module service_asserts (
   input logic                   CLK,
   input logic                   RESETN,
   input logic                   enable,
   input logic                   req_valid,
   input logic                   req_ready,
   input logic                   in_idle,
   input logic                   wvalid,
   input logic                   wrdy,
   input service_pkg::svc_word_t wdata
);

   // Enable is a single cycle pulse
   enable_one_cycle: assert property (@(posedge CLK) disable iff (!RESETN)
      enable |=> !enable)
      else $error("serv_enable_req high for more than one cycle");

   // Accepted request leaves IDLE for the enable cycle
   accept_to_issue: assert property (@(posedge CLK) disable iff (!RESETN)
      (req_valid && req_ready) |=> (!in_idle && enable))
      else $error("accepted request did not move on to the enable cycle");

   // Stalled word stays on offer unchanged
   word_hold: assert property (@(posedge CLK) disable iff (!RESETN)
      (wvalid && !wrdy) |=> (wvalid && $stable(wdata)))
      else $error("write word or valid changed while wrdy low");

endmodule

//--- service_defs.svh
// Width, command code, payload start and descriptor constant defines
`ifndef SERVICE_DEFS_SVH
`define SERVICE_DEFS_SVH

// ==============================
// Field widths
// ==============================
`define SVC_CMD_W    8
`define SVC_WORD_W   32
`define SVC_COUNT_W  6
`define CRYPTO_KEY_W 256
`define CRYPTO_IV_W  128

// ==============================
// Service command codes
// ==============================
`define CMD_SERIAL   8'd1
`define CMD_AES128   8'd3
`define CMD_USERCODE 8'd4
`define CMD_AES256   8'd6
`define CMD_SHA256   8'd10
`define CMD_HMAC     8'd12
`define CMD_SELFTEST 8'd40
// NRBG group
`define CMD_INST     8'd41
`define CMD_GEN      8'd42
`define CMD_RESEED   8'd43
`define CMD_UNINST   8'd44

// First payload word of every stream
`define PAYLOAD_START 32'd2

// ==============================
// Descriptor constants
// ==============================
// Byte count pattern 01..20 with LSB first
`define KEY_PATTERN  256'h201F1E1D_1C1B1A19_18171615_14131211_100F0E0D_0C0B0A09_08070605_04030201
`define KEY_LOW128   128'h100F_0E0D_0C0B_0A09_0807_0605_0403_0201
`define IV_PATTERN_A 128'h201F_1E1D_1C1B_1A19_1817_1615_1413_1211
`define IV_PATTERN_B 128'h302F_2E2D_2C2B_2A29_2827_2625_2423_2221
// AES direction
`define AES_MODE_ENC 8'd0
`define AES_MODE_DEC 8'd1
// Handle value used by all NRBG calls
`define NRBG_HANDLE  8'hFF

`endif

//--- service_driver_top.sv
// System service driver top with sequencer, descriptor builder and streamer

module service_driver_top (
   input  logic                   CLK,
   input  logic                   RESETN,
   // Request port
   input  logic                   req_valid,
   input  service_pkg::svc_cmd_t  req_cmd,
   output logic                   req_ready,
   // Service port
   output logic                   serv_enable_req,
   output service_pkg::svc_cmd_t  serv_cmdbyte_req,
   output service_pkg::svc_desc_t serv_desc,
   input  logic                   serv_busy,
   // Write port
   output logic                   serv_data_wvalid,
   output service_pkg::svc_word_t serv_data_w,
   input  logic                   serv_data_wrdy
);

   // Acceptance pulse and code
   logic                    start;
   service_pkg::svc_cmd_t   start_cmd;
   // Builder to streamer
   service_pkg::svc_count_t word_count;
   // Streamer back to sequencer
   logic                    stream_done;

   // ==============================
   // Control
   // ==============================
   service_sequencer i_seq (
      .CLK             (CLK),
      .RESETN          (RESETN),
      .req_valid       (req_valid),
      .req_cmd         (req_cmd),
      .stream_done     (stream_done),
      .serv_busy       (serv_busy),
      .req_ready       (req_ready),
      .start           (start),
      .start_cmd       (start_cmd),
      .serv_enable_req (serv_enable_req)
   );

   // Descriptor and count registered into the enable cycle
   descriptor_builder i_desc (
      .CLK              (CLK),
      .RESETN           (RESETN),
      .start            (start),
      .start_cmd        (start_cmd),
      .serv_cmdbyte_req (serv_cmdbyte_req),
      .serv_desc        (serv_desc),
      .word_count       (word_count)
   );

   // Payload loaded by the enable pulse
   payload_streamer i_stream (
      .CLK              (CLK),
      .RESETN           (RESETN),
      .load             (serv_enable_req),
      .word_count       (word_count),
      .serv_data_wrdy   (serv_data_wrdy),
      .serv_data_wvalid (serv_data_wvalid),
      .serv_data_w      (serv_data_w),
      .stream_done      (stream_done)
   );

endmodule

//--- service_pkg.sv
// Service vector typedefs, descriptor struct and sequencer state enum
`include "service_defs.svh"

package service_pkg;

   // ==============================
   // Plain vector types
   // ==============================
   // Command code in, command byte out
   typedef logic [`SVC_CMD_W-1:0]    svc_cmd_t;
   // One payload word on the write port
   typedef logic [`SVC_WORD_W-1:0]   svc_word_t;
   // Words still to send
   typedef logic [`SVC_COUNT_W-1:0]  svc_count_t;
   typedef logic [`CRYPTO_KEY_W-1:0] crypto_key_t;
   typedef logic [`CRYPTO_IV_W-1:0]  crypto_iv_t;

   // ==============================
   // Service descriptor
   // ==============================
   // Valid only in the enable cycle, zero otherwise
   typedef struct packed {
      crypto_key_t key;
      crypto_iv_t  iv;
      // 0 encrypt, 1 decrypt
      logic [7:0]  mode;
      // Count of 128-bit blocks
      logic [15:0] nblocks;
      logic [31:0] length;
      // NRBG fields
      logic [7:0]  nrbg_length;
      logic [7:0]  nrbg_handle;
      logic [7:0]  nrbg_addlength;
      logic [7:0]  nrbg_prreq;
   } svc_desc_t;

   // Request sequencer states
   typedef enum logic [1:0] {
      IDLE,
      ISSUE,
      STREAM,
      WAIT_BUSY
   } seq_state_t;

endpackage

//--- service_sequencer.sv
// Request accept, enable pulse and busy wait state machine

module service_sequencer (
   input  logic                  CLK,
   input  logic                  RESETN,
   input  logic                  req_valid,
   input  service_pkg::svc_cmd_t req_cmd,
   input  logic                  stream_done,
   input  logic                  serv_busy,
   output logic                  req_ready,
   output logic                  start,
   output service_pkg::svc_cmd_t start_cmd,
   output logic                  serv_enable_req
);

   service_pkg::seq_state_t state;
   service_pkg::seq_state_t state_nxt;

   // ==============================
   // Request side
   // ==============================
   // Ready only when no service is in flight
   assign req_ready = (state == service_pkg::IDLE);
   assign start     = req_valid && req_ready;
   // Code passed to the builder only with start
   assign start_cmd = start ? req_cmd : '0;

   // One cycle enable in the cycle after acceptance
   assign serv_enable_req = (state == service_pkg::ISSUE);

   // ==============================
   // Next state
   // ==============================
   always_comb begin
      state_nxt = state;
      case (state)
         service_pkg::IDLE: begin
            if (start) begin
               state_nxt = service_pkg::ISSUE;
            end
         end
         // Zero-word services finish here
         service_pkg::ISSUE: begin
            if (stream_done) begin
               state_nxt = service_pkg::WAIT_BUSY;
            end else begin
               state_nxt = service_pkg::STREAM;
            end
         end
         // Wait for the last word to be taken
         service_pkg::STREAM: begin
            if (stream_done) begin
               state_nxt = service_pkg::WAIT_BUSY;
            end
         end
         // Service must drop busy before next request
         service_pkg::WAIT_BUSY: begin
            if (!serv_busy) begin
               state_nxt = service_pkg::IDLE;
            end
         end
         default: begin
            state_nxt = service_pkg::IDLE;
         end
      endcase
   end

   // State register
   always_ff @(posedge CLK or negedge RESETN) begin
      if (!RESETN) begin
         state <= service_pkg::IDLE;
      end else begin
         state <= state_nxt;
      end
   end

endmodule

//--- service_stim.txt
// cmd cmdbyte words mode nblocks length, all hex
// One request per line, expected values for its enable cycle
01 01 00 00 0000 00000000
03 03 04 01 0001 00000000
06 06 08 00 0002 00000001
0a 0a 02 00 0000 00000021
0c 0c 03 00 0000 00000009
04 04 00 00 0000 00000000
28 28 00 00 0000 00000000
29 29 01 00 0000 00000000
2a 2a 01 00 0000 00000000
2b 2b 02 00 0000 00000000
2c 2c 00 00 0000 00000000
07 01 00 00 0000 00000000
ff 01 00 00 0000 00000000
06 06 08 00 0002 00000001
03 03 04 01 0001 00000000

//--- tb_service_driver.sv
// Testbench with clock, reset, service model, stimulus reader, monitor and checks
`include "service_defs.svh"

module tb_service_driver;

   // One stimulus line
   typedef struct packed {
      logic [7:0]  cmd;
      logic [7:0]  cmdbyte;
      logic [5:0]  words;
      logic [7:0]  mode;
      logic [15:0] nblocks;
      logic [31:0] length;
   } stim_t;

   logic                   CLK = 1'b0;
   logic                   RESETN = 1'b0;
   logic                   req_valid = 1'b0;
   service_pkg::svc_cmd_t  req_cmd = '0;
   logic                   req_ready;
   logic                   serv_enable_req;
   service_pkg::svc_cmd_t  serv_cmdbyte_req;
   service_pkg::svc_desc_t serv_desc;
   logic                   serv_busy = 1'b0;
   logic                   serv_data_wvalid;
   service_pkg::svc_word_t serv_data_w;
   logic                   serv_data_wrdy = 1'b0;

   stim_t       stim_q[$];
   stim_t       cur = '0;
   integer      seed = 32'hcc5b;
   logic [31:0] rnd;
   logic [2:0]  busy_left = 3'd0;
   int          value_errors = 0;
   int          other_errors = 0;
   int          cycles = 0;
   int          cycle_limit = 0;
   // Request in flight as seen by the monitor
   logic        in_flight = 1'b0;
   logic        tail = 1'b0;
   logic        busy_low_seen = 1'b0;
   int          enables = 0;
   int          words_got = 0;

   always #4 CLK = ~CLK;

   service_driver_top i_dut (
      .CLK              (CLK),
      .RESETN           (RESETN),
      .req_valid        (req_valid),
      .req_cmd          (req_cmd),
      .req_ready        (req_ready),
      .serv_enable_req  (serv_enable_req),
      .serv_cmdbyte_req (serv_cmdbyte_req),
      .serv_desc        (serv_desc),
      .serv_busy        (serv_busy),
      .serv_data_wvalid (serv_data_wvalid),
      .serv_data_w      (serv_data_w),
      .serv_data_wrdy   (serv_data_wrdy)
   );

   bind service_sequencer service_asserts i_seq_asserts (
      .CLK       (CLK),
      .RESETN    (RESETN),
      .enable    (serv_enable_req),
      .req_valid (req_valid),
      .req_ready (req_ready),
      .in_idle   (state == service_pkg::IDLE),
      .wvalid    (1'b0),
      .wrdy      (1'b1),
      .wdata     (32'd0)
   );

   bind payload_streamer service_asserts i_stream_asserts (
      .CLK       (CLK),
      .RESETN    (RESETN),
      .enable    (load),
      .req_valid (1'b0),
      .req_ready (1'b0),
      .in_idle   (1'b1),
      .wvalid    (serv_data_wvalid),
      .wrdy      (serv_data_wrdy),
      .wdata     (serv_data_w)
   );

   // ==============================
   // Helpers
   // ==============================
   task automatic check_value(input string name, input logic [511:0] got,
                              input logic [511:0] expected);
      if (got !== expected) begin
         value_errors++;
         $display("[ERROR] %s: got %0h, expected %0h at %0t", name, got, expected, $time);
      end
   endtask

   task automatic report_counts();
      $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
   endtask

   // Hex columns with comment lines skipped
   task automatic read_stim();
      integer           fd;
      integer           n;
      integer           got_line;
      logic             done;
      logic [8*128-1:0] line_buf;
      logic [31:0]      f_cmd;
      logic [31:0]      f_byte;
      logic [31:0]      f_words;
      logic [31:0]      f_mode;
      logic [31:0]      f_nblk;
      logic [31:0]      f_len;
      stim_t            entry;
      done = 1'b0;
      fd = $fopen("service_stim.txt", "r");
      if (fd == 0) begin
         $display("Could not open service_stim.txt for reading");
         other_errors++;
         done = 1'b1;
      end
      while (!done) begin
         n = $fscanf(fd, "%h %h %h %h %h %h\n", f_cmd, f_byte, f_words, f_mode, f_nblk, f_len);
         if (n == 6) begin
            entry.cmd     = f_cmd[7:0];
            entry.cmdbyte = f_byte[7:0];
            entry.words   = f_words[5:0];
            entry.mode    = f_mode[7:0];
            entry.nblocks = f_nblk[15:0];
            entry.length  = f_len;
            stim_q.push_back(entry);
         end else if (n == 0) begin
            // Comment line
            got_line = $fgets(line_buf, fd);
            if (got_line == 0) begin
               done = 1'b1;
            end
         end else if (n < 0) begin
            done = 1'b1;
         end else begin
            $display("Malformed line in service_stim.txt after %0d entries", stim_q.size());
            other_errors++;
            done = 1'b1;
         end
      end
      if (fd != 0) begin
         $fclose(fd);
      end
   endtask

   // Key, IV and NRBG fields from the command table
   // Remaining fields from the stim line
   task automatic check_enable_cycle();
      service_pkg::crypto_key_t ek;
      service_pkg::crypto_iv_t  ei;
      logic [7:0]               e_len;
      logic [7:0]               e_hdl;
      logic [7:0]               e_add;
      ek    = '0;
      ei    = '0;
      e_len = 8'd0;
      e_hdl = 8'd0;
      e_add = 8'd0;
      case (cur.cmd)
         `CMD_AES128: begin
            ek = {128'd0, `KEY_LOW128};
            ei = `IV_PATTERN_A;
         end
         `CMD_AES256: begin
            ek = `KEY_PATTERN;
            ei = `IV_PATTERN_B;
         end
         `CMD_HMAC: begin
            ek = `KEY_PATTERN;
         end
         `CMD_INST: begin
            e_len = 8'd4;
            e_hdl = 8'hFF;
         end
         `CMD_RESEED: begin
            e_len = 8'd32;
            e_hdl = 8'hFF;
            e_add = 8'd7;
         end
         `CMD_UNINST: begin
            e_hdl = 8'hFF;
         end
         default: begin
         end
      endcase
      check_value("serv_cmdbyte_req", 512'(serv_cmdbyte_req), 512'(cur.cmdbyte));
      check_value("serv_desc.mode", 512'(serv_desc.mode), 512'(cur.mode));
      check_value("serv_desc.nblocks", 512'(serv_desc.nblocks), 512'(cur.nblocks));
      check_value("serv_desc.length", 512'(serv_desc.length), 512'(cur.length));
      check_value("serv_desc.key", 512'(serv_desc.key), 512'(ek));
      check_value("serv_desc.iv", 512'(serv_desc.iv), 512'(ei));
      check_value("serv_desc.nrbg_length", 512'(serv_desc.nrbg_length), 512'(e_len));
      check_value("serv_desc.nrbg_handle", 512'(serv_desc.nrbg_handle), 512'(e_hdl));
      check_value("serv_desc.nrbg_addlength", 512'(serv_desc.nrbg_addlength), 512'(e_add));
      check_value("serv_desc.nrbg_prreq", 512'(serv_desc.nrbg_prreq), 512'd0);
   endtask

   // ==============================
   // Service model
   // ==============================
   // Random wrdy stalls and busy for 0 to 7 cycles from each enable
   always @(posedge CLK) begin
      #1;
      rnd = $random(seed);
      serv_data_wrdy = rnd[0];
      if (serv_enable_req) begin
         busy_left = rnd[6:4];
      end else if (busy_left != 3'd0) begin
         busy_left = busy_left - 3'd1;
      end
      serv_busy = (busy_left != 3'd0);
   end

   // ==============================
   // Mid-cycle monitor
   // ==============================
   always @(negedge CLK) begin
      if (RESETN) begin
         // Request ends when ready returns
         if (in_flight && req_ready) begin
            check_value("word count", 512'(words_got), 512'(cur.words));
            check_value("serv_enable_req pulses", 512'(enables), 512'd1);
            check_value("serv_busy low before req_ready", 512'(busy_low_seen), 512'd1);
            in_flight = 1'b0;
         end
         if (!in_flight && req_valid && req_ready) begin
            in_flight     = 1'b1;
            tail          = 1'b0;
            busy_low_seen = 1'b0;
            enables       = 0;
            words_got     = 0;
         end
         // Busy counts only after the last word or the enable
         if (tail && !serv_busy) begin
            busy_low_seen = 1'b1;
         end
         if (serv_enable_req) begin
            enables++;
            check_enable_cycle();
            if (cur.words == 6'd0) begin
               tail = 1'b1;
            end
         end else begin
            check_value("serv_cmdbyte_req", 512'(serv_cmdbyte_req), 512'd0);
            check_value("serv_desc", 512'(serv_desc), 512'd0);
         end
         if (serv_data_wvalid && serv_data_wrdy) begin
            check_value("serv_data_w", 512'(serv_data_w),
                        512'(`PAYLOAD_START + 32'(words_got)));
            words_got++;
            if (words_got == int'(cur.words)) begin
               tail = 1'b1;
            end
         end
      end
   end

   // Watchdog
   always @(posedge CLK) begin
      cycles++;
      if (cycle_limit > 0 && cycles > cycle_limit) begin
         $display("Timeout: run did not finish within %0d cycles", cycle_limit);
         other_errors++;
         report_counts();
         $display("CHECKS FAILED");
         $finish;
      end
   end

   // ==============================
   // Main sequence
   // ==============================
   initial begin
      integer idx;
      read_stim();
      if (stim_q.size() == 0 && other_errors == 0) begin
         $display("No stimulus lines found in service_stim.txt");
         other_errors++;
      end
      cycle_limit = 200 * stim_q.size() + 20;
      repeat (4) @(posedge CLK);
      #1;
      RESETN = 1'b1;
      @(negedge CLK);
      check_value("req_ready", 512'(req_ready), 512'd1);
      check_value("serv_enable_req", 512'(serv_enable_req), 512'd0);
      check_value("serv_data_wvalid", 512'(serv_data_wvalid), 512'd0);
      for (idx = 0; idx < stim_q.size(); idx++) begin
         @(posedge CLK);
         #1;
         cur       = stim_q[idx];
         req_cmd   = cur.cmd;
         req_valid = 1'b1;
         @(negedge CLK);
         while (!req_ready) @(negedge CLK);
         // Taken at the next edge
         @(posedge CLK);
         #1;
         req_valid = 1'b0;
         req_cmd   = '0;
         @(negedge CLK);
         while (!req_ready) @(negedge CLK);
      end
      // Monitor closes the last request at that same falling edge
      @(posedge CLK);
      report_counts();
      if (value_errors == 0 && other_errors == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule
